/* bench/core_control_tb_tasks.svh */
task automatic check_word(input string name, input word got, input word exp);
	if (got !== exp) begin
		report_failure($sformatf("CHECK FAILED at %0.1f ns: %s = %h, expected %h",
			$realtime, name, got, exp));
	end
endtask

task automatic check_flags(input string name, input psr_flags got, input psr_flags exp);
	if (got !== exp) begin
		report_failure($sformatf("CHECK FAILED at %0.1f ns: %s = %b, expected %b",
			$realtime, name, got, exp));
	end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		report_failure($sformatf("CHECK FAILED at %0.1f ns: %s = %b, expected %b",
			$realtime, name, got, exp));
	end
endtask

task automatic check_count(input string name, input int got, input int exp);
	if (got != exp) begin
		report_failure($sformatf("CHECK FAILED at %0.1f ns: %s = %0d, expected %0d",
			$realtime, name, got, exp));
	end
endtask

function automatic insn_issue make_insn(input logic wb, ld, st, mul, bwb, uf,
	input reg_num rd, ra, rd_hi);
	insn_issue i;
	i = '0;
	i.dec.writeback = wb;
	i.dec.is_load = ld;
	i.dec.is_store = st;
	i.dec.is_mul_long = mul;
	i.dec.base_wb = bwb;
	i.dec_psr.update_flags = uf;
	i.dec_data.rd = rd;
	i.dec_data.ra = ra;
	i.dec_data.rd_hi = rd_hi;
	return i;
endfunction

// called on a falling edge, returns on the falling edge after the strobe edge
task automatic issue_insn(input insn_issue i);
	check_bit("idle", idle, 1'b1);
	insn = i;
	insn_valid = 1'b1;
	@(posedge clk);
	@(negedge clk);
	insn_valid = 1'b0;
endtask

task automatic raise_exception();
	check_bit("idle", idle, 1'b1);
	exc_req = 1'b1;
	@(posedge clk);
	@(negedge clk);
	exc_req = 1'b0;
endtask

// read data only valid during the strobe
task automatic pulse_mem_ready(input word data);
	check_bit("mem_req", mem_req, 1'b1);
	mem_ready = 1'b1;
	mem_data_rd = data;
	@(posedge clk);
	@(negedge clk);
	mem_ready = 1'b0;
	mem_data_rd = rand_bits(32);
endtask

// clock edges from the strobe edge until idle is back
task automatic wait_idle(output int edges);
	edges = 0;
	while (!idle) begin
		@(negedge clk);
		edges++;
	end
endtask

task automatic read_reg(input int n, output word got);
	@(negedge clk);
	rs = reg_num'(n);
	#1;
	got = rs_data;
endtask

task automatic verify_state();
	word got;
	for (int i = 0; i < `CORE_NUM_REGS; i++) begin
		read_reg(i, got);
		check_word($sformatf("r%0d", i), got, exp_regs[i]);
	end
	check_flags("flags", flags, exp_flags);
endtask

/* bench/core_control_tb.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module core_control_tb;

	import core_types_pkg::*;
	import core_decode_pkg::*;

	localparam int NUM_TESTS   = 9;
	localparam int CYCLE_LIMIT = 200 * NUM_TESTS;

	logic      clk;
	logic      arst_n;
	insn_issue insn;
	logic      insn_valid;
	logic      exc_req;
	word       q_alu;
	psr_flags  alu_flags;
	word       mul_q_hi;
	word       mul_q_lo;
	word       mem_data_rd;
	logic      mem_ready;
	word       saved_base;
	word       vector;
	word       link;
	reg_num    rs;
	word       rs_data;
	psr_flags  flags;
	logic      idle;
	logic      mem_req;

	// expected architectural state
	word         exp_regs [`CORE_NUM_REGS];
	psr_flags    exp_flags;
	logic [31:0] lfsr_state;

	core_control_top uut (
		.clk         (clk),
		.arst_n      (arst_n),
		.insn        (insn),
		.insn_valid  (insn_valid),
		.exc_req     (exc_req),
		.q_alu       (q_alu),
		.alu_flags   (alu_flags),
		.mul_q_hi    (mul_q_hi),
		.mul_q_lo    (mul_q_lo),
		.mem_data_rd (mem_data_rd),
		.mem_ready   (mem_ready),
		.saved_base  (saved_base),
		.vector      (vector),
		.link        (link),
		.rs          (rs),
		.rs_data     (rs_data),
		.flags       (flags),
		.idle        (idle),
		.mem_req     (mem_req)
	);

	`include "core_control_tb_tasks.svh"

	// galois form, taps x^32 + x^22 + x^2 + x + 1
	function automatic logic next_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b) begin
			lfsr_state = lfsr_state ^ 32'h8020_0003;
		end
		return b;
	endfunction

	function automatic word rand_bits(input int n);
		word v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], next_bit()};
		end
		return v;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic test_reset();
		check_bit("idle", idle, 1'b1);
		check_bit("mem_req", mem_req, 1'b0);
		verify_state();
	endtask

	task automatic test_alu(input reg_num rd, input logic wb);
		word r;
		int  edges;
		@(negedge clk);
		q_alu = rand_bits(32);
		r = rand_bits(4);
		alu_flags = r[3:0];
		issue_insn(make_insn(wb, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, rd, 4'd0, 4'd0));
		wait_idle(edges);
		check_count("alu latency", edges, 2);
		if (wb) begin
			exp_regs[rd] = q_alu;
		end
		exp_flags = alu_flags;
		verify_state();
	endtask

	task automatic test_load(input reg_num rd, input reg_num ra, input logic bwb);
		word data;
		int  delay;
		int  edges;
		delay = rand_bits(3);
		data = rand_bits(32);
		@(negedge clk);
		saved_base = rand_bits(32);
		mem_data_rd = rand_bits(32);
		issue_insn(make_insn(1'b1, 1'b1, 1'b0, 1'b0, bwb, 1'b0, rd, ra, 4'd0));
		repeat (delay) @(negedge clk);
		pulse_mem_ready(data);
		wait_idle(edges);
		check_count("load latency", edges, bwb ? 3 : 2);
		exp_regs[rd] = data;
		if (bwb) begin
			exp_regs[ra] = saved_base;
		end
		verify_state();
	endtask

	// writeback bit set on purpose, a store must still leave rd alone
	task automatic test_store(input reg_num ra, input logic bwb);
		int delay;
		int edges;
		delay = rand_bits(3);
		@(negedge clk);
		saved_base = rand_bits(32);
		issue_insn(make_insn(1'b1, 1'b0, 1'b1, 1'b0, bwb, 1'b0, 4'd2, ra, 4'd0));
		repeat (delay) @(negedge clk);
		pulse_mem_ready(rand_bits(32));
		wait_idle(edges);
		if (bwb) begin
			exp_regs[ra] = saved_base;
		end
		verify_state();
	endtask

	task automatic test_mul(input reg_num rd, input reg_num rd_hi);
		int edges;
		@(negedge clk);
		mul_q_lo = rand_bits(32);
		mul_q_hi = rand_bits(32);
		issue_insn(make_insn(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, rd, 4'd0, rd_hi));
		wait_idle(edges);
		check_count("mul latency", edges, 3);
		exp_regs[rd] = mul_q_lo;
		exp_regs[rd_hi] = mul_q_hi;
		verify_state();
	endtask

	task automatic test_exception();
		int edges;
		@(negedge clk);
		vector = rand_bits(32);
		link = rand_bits(32);
		raise_exception();
		wait_idle(edges);
		check_count("exception latency", edges, 3);
		exp_regs[`R15] = vector;
		exp_regs[`R14] = link;
		verify_state();
	endtask

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial begin
		repeat (CYCLE_LIMIT) @(posedge clk);
		report_failure($sformatf("timeout: no result after %0d clock cycles", CYCLE_LIMIT));
	end

	initial begin
		arst_n = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		exc_req = 1'b0;
		q_alu = '0;
		alu_flags = '0;
		mul_q_hi = '0;
		mul_q_lo = '0;
		mem_data_rd = '0;
		mem_ready = 1'b0;
		saved_base = '0;
		vector = '0;
		link = '0;
		rs = '0;
		lfsr_state = 32'h01ee_b1e4;
		exp_flags = '0;
		for (int i = 0; i < `CORE_NUM_REGS; i++) begin
			exp_regs[i] = '0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		test_reset();
		test_alu(4'd3, 1'b1);
		test_alu(4'd3, 1'b0);
		test_load(4'd4, 4'd1, 1'b0);
		test_load(4'd5, 4'd6, 1'b1);
		test_store(4'd7, 1'b0);
		test_store(4'd8, 1'b1);
		test_mul(4'd9, 4'd10);
		test_exception();

		$display("TESTS PASSED");
		$finish;
	end

endmodule

/* core_control.f */
+incdir+rtl
+incdir+bench
rtl/core_types_pkg.sv
rtl/core_decode_pkg.sv
rtl/core_issue_latch.sv
rtl/core_cycle_sequencer.sv
rtl/core_control_writeback.sv
rtl/core_register_file.sv
rtl/core_control_top.sv
bench/core_control_tb.sv

/* rtl/core_control_top.sv */
`timescale 1ns/10ps

module core_control_top (
	input  logic                       clk,
	input  logic                       arst_n,
	input  core_decode_pkg::insn_issue insn,
	input  logic                       insn_valid,
	input  logic                       exc_req,
	input  core_types_pkg::word        q_alu,
	input  core_types_pkg::psr_flags   alu_flags,
	input  core_types_pkg::word        mul_q_hi,
	input  core_types_pkg::word        mul_q_lo,
	input  core_types_pkg::word        mem_data_rd,
	input  logic                       mem_ready,
	input  core_types_pkg::word        saved_base,
	input  core_types_pkg::word        vector,
	input  core_types_pkg::word        link,
	input  core_types_pkg::reg_num     rs,
	output core_types_pkg::word        rs_data,
	output core_types_pkg::psr_flags   flags,
	output logic                       idle,
	output logic                       mem_req
);

	import core_types_pkg::*;
	import core_decode_pkg::*;

	insn_issue held;
	logic      issue;
	logic      exc_issue;
	ctrl_cycle cycle;
	ctrl_cycle next_cycle;
	logic      final_pending;
	reg_num    rd;
	logic      writeback;
	logic      update_flags;
	word       wr_value;
	psr_flags  wb_alu_flags;

	// input side
	core_issue_latch u_issue_latch (
		.clk        (clk),
		.arst_n     (arst_n),
		.insn       (insn),
		.insn_valid (insn_valid),
		.exc_req    (exc_req),
		.idle       (idle),
		.held       (held),
		.issue      (issue),
		.exc_issue  (exc_issue)
	);

	core_cycle_sequencer u_sequencer (
		.clk           (clk),
		.arst_n        (arst_n),
		.held          (held),
		.issue         (issue),
		.exc_issue     (exc_issue),
		.mem_ready     (mem_ready),
		.final_pending (final_pending),
		.cycle         (cycle),
		.next_cycle    (next_cycle),
		.idle          (idle),
		.mem_req       (mem_req)
	);

	core_control_writeback u_writeback (
		.clk           (clk),
		.arst_n        (arst_n),
		.held          (held),
		.alu_flags     (alu_flags),
		.q_alu         (q_alu),
		.mem_data_rd   (mem_data_rd),
		.mul_q_hi      (mul_q_hi),
		.mul_q_lo      (mul_q_lo),
		.saved_base    (saved_base),
		.vector        (vector),
		.link          (link),
		.mem_ready     (mem_ready),
		.issue         (issue),
		.cycle         (cycle),
		.next_cycle    (next_cycle),
		.rd            (rd),
		.writeback     (writeback),
		.update_flags  (update_flags),
		.final_pending (final_pending),
		.wr_value      (wr_value),
		.wb_alu_flags  (wb_alu_flags)
	);

	// output side
	core_register_file u_register_file (
		.clk          (clk),
		.arst_n       (arst_n),
		.rd           (rd),
		.writeback    (writeback),
		.update_flags (update_flags),
		.wr_value     (wr_value),
		.wb_alu_flags (wb_alu_flags),
		.rs           (rs),
		.rs_data      (rs_data),
		.flags        (flags)
	);

endmodule

/* rtl/core_control_writeback.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module core_control_writeback (
	input  logic                       clk,
	input  logic                       arst_n,
	input  core_decode_pkg::insn_issue held,
	input  core_types_pkg::psr_flags   alu_flags,
	input  core_types_pkg::word        q_alu,
	input  core_types_pkg::word        mem_data_rd,
	input  core_types_pkg::word        mul_q_hi,
	input  core_types_pkg::word        mul_q_lo,
	input  core_types_pkg::word        saved_base,
	input  core_types_pkg::word        vector,
	input  core_types_pkg::word        link,
	input  logic                       mem_ready,
	input  logic                       issue,
	input  core_types_pkg::ctrl_cycle  cycle,
	input  core_types_pkg::ctrl_cycle  next_cycle,
	output core_types_pkg::reg_num     rd,
	output logic                       writeback,
	output logic                       update_flags,
	output logic                       final_pending,
	output core_types_pkg::word        wr_value,
	output core_types_pkg::psr_flags   wb_alu_flags
);

	import core_types_pkg::*;

	reg_num final_rd;
	logic   final_writeback;
	logic   final_update_flags;
	logic   final_alu;
	word    final_value;
	logic   pending;

	logic exc_start;
	logic mul_split;
	logic base_split;
	logic release_final;
	logic mem_capture;

	assign exc_start = (cycle == ISSUE) && (next_cycle == EXCEPTION);

	// cycles that write one register and queue the next one
	assign mul_split  = (next_cycle == MUL_HI_WB);
	assign base_split = (cycle == BASE_WRITEBACK);

	assign release_final = pending && (cycle == ISSUE || cycle == MUL_HI_WB);
	assign mem_capture   = (cycle == TRANSFER) && mem_ready;

	// busy until the last write has left the port
	assign final_pending = pending || writeback || update_flags;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd                 <= '0;
			writeback          <= 1'b0;
			update_flags       <= 1'b0;
			final_rd           <= '0;
			final_writeback    <= 1'b0;
			final_update_flags <= 1'b0;
			final_alu          <= 1'b0;
			pending            <= 1'b0;
		end else begin
			writeback    <= 1'b0;
			update_flags <= 1'b0;

			if (issue) begin
				final_rd           <= held.dec_data.rd;
				final_writeback    <= held.dec.writeback && !held.dec.is_store;
				final_update_flags <= held.dec_psr.update_flags;
				final_alu          <= !held.dec.is_load;
				pending            <= 1'b1;
			end else if (exc_start) begin
				// pc first, link register last
				rd                 <= `R15;
				final_rd           <= `R14;
				final_writeback    <= 1'b1;
				final_update_flags <= 1'b0;
				final_alu          <= 1'b0;
				pending            <= 1'b1;
			end else if (cycle == EXCEPTION) begin
				writeback <= 1'b1;
			end else if (mul_split || base_split) begin
				rd                 <= final_rd;
				writeback          <= final_writeback;
				update_flags       <= final_update_flags;
				final_rd           <= mul_split ? held.dec_data.rd_hi : held.dec_data.ra;
				final_writeback    <= mul_split ? held.dec.writeback : 1'b1;
				final_update_flags <= 1'b0;
				final_alu          <= 1'b0;
			end else if (release_final) begin
				rd           <= final_rd;
				writeback    <= final_writeback;
				update_flags <= final_update_flags;
				pending      <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		wb_alu_flags <= alu_flags;

		if (exc_start) begin
			wr_value    <= vector;
			final_value <= link;
		end else if (mem_capture) begin
			// read data is only valid with the strobe
			final_value <= mem_data_rd;
		end else if (mul_split) begin
			wr_value    <= mul_q_lo;
			final_value <= mul_q_hi;
		end else if (base_split) begin
			wr_value    <= final_value;
			final_value <= saved_base;
		end else if (release_final) begin
			wr_value <= final_alu ? q_alu : final_value;
		end
	end

endmodule

/* rtl/core_cycle_sequencer.sv */
`timescale 1ns/10ps

module core_cycle_sequencer (
	input  logic                       clk,
	input  logic                       arst_n,
	input  core_decode_pkg::insn_issue held,
	input  logic                       issue,
	input  logic                       exc_issue,
	input  logic                       mem_ready,
	input  logic                       final_pending,
	output core_types_pkg::ctrl_cycle  cycle,
	output core_types_pkg::ctrl_cycle  next_cycle,
	output logic                       idle,
	output logic                       mem_req
);

	import core_types_pkg::*;

	always_comb begin
		next_cycle = ISSUE;
		unique case (cycle)
			ISSUE: begin
				if (exc_issue) begin
					next_cycle = EXCEPTION;
				end else if (issue) begin
					if (held.dec.is_load || held.dec.is_store) begin
						next_cycle = TRANSFER;
					end else if (held.dec.is_mul_long) begin
						next_cycle = MUL;
					end
				end
			end

			TRANSFER: begin
				// memory wait, any length
				if (!mem_ready) begin
					next_cycle = TRANSFER;
				end else if (held.dec.base_wb) begin
					next_cycle = BASE_WRITEBACK;
				end
			end

			MUL:
				next_cycle = MUL_HI_WB;

			default:
				next_cycle = ISSUE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cycle <= ISSUE;
		end else begin
			cycle <= next_cycle;
		end
	end

	// a deferred write keeps the core busy
	assign idle = (cycle == ISSUE) && !final_pending;

	assign mem_req = (cycle == TRANSFER);

endmodule

/* rtl/core_decode_pkg.sv */
package core_decode_pkg;

	// what the instruction does to the datapath
	typedef struct packed {
		logic writeback;
		logic is_load;
		logic is_store;
		logic is_mul_long;
		logic base_wb;
	} datapath_decode;

	typedef struct packed {
		logic update_flags;
	} psr_decode;

	// register operands
	typedef struct packed {
		core_types_pkg::reg_num rd;
		core_types_pkg::reg_num ra;
		core_types_pkg::reg_num rd_hi;
	} data_decode;

	// one decoded instruction as carried by the issue strobe
	typedef struct packed {
		datapath_decode dec;
		psr_decode      dec_psr;
		data_decode     dec_data;
	} insn_issue;

endpackage

/* rtl/core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// architectural register file size
`define CORE_NUM_REGS 16

// link register and program counter
`define R14 4'd14
`define R15 4'd15

`endif

/* rtl/core_issue_latch.sv */
`timescale 1ns/10ps

module core_issue_latch (
	input  logic                       clk,
	input  logic                       arst_n,
	input  core_decode_pkg::insn_issue insn,
	input  logic                       insn_valid,
	input  logic                       exc_req,
	input  logic                       idle,
	output core_decode_pkg::insn_issue held,
	output logic                       issue,
	output logic                       exc_issue
);

	import core_decode_pkg::*;

	insn_issue held_q;

	// strobes outside idle are dropped
	assign exc_issue = exc_req && idle;

	// exception request wins over an instruction in the same cycle
	assign issue = insn_valid && idle && !exc_req;

	// the new instruction is visible in its issue cycle already
	assign held = issue ? insn : held_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			held_q <= '0;
		end else if (issue) begin
			held_q <= insn;
		end
	end

endmodule

/* rtl/core_register_file.sv */
`timescale 1ns/10ps
`include "core_defines.svh"

module core_register_file (
	input  logic                     clk,
	input  logic                     arst_n,
	input  core_types_pkg::reg_num   rd,
	input  logic                     writeback,
	input  logic                     update_flags,
	input  core_types_pkg::word      wr_value,
	input  core_types_pkg::psr_flags wb_alu_flags,
	input  core_types_pkg::reg_num   rs,
	output core_types_pkg::word      rs_data,
	output core_types_pkg::psr_flags flags
);

	import core_types_pkg::*;

	word regs [`CORE_NUM_REGS];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `CORE_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			flags <= '0;
		end else begin
			if (writeback) begin
				regs[rd] <= wr_value;
			end
			if (update_flags) begin
				flags <= wb_alu_flags;
			end
		end
	end

	// operand port, no bypass of a write in flight
	assign rs_data = regs[rs];

endmodule

/* rtl/core_types_pkg.sv */
`include "core_defines.svh"

package core_types_pkg;

	// data path word
	typedef logic [31:0] word;

	// register index, wide enough for the whole file
	typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_num;

	// condition flags as stored in the psr
	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	// control cycles of one instruction
	typedef enum logic [2:0] {
		ISSUE,
		TRANSFER,
		BASE_WRITEBACK,
		MUL,
		MUL_HI_WB,
		EXCEPTION
	} ctrl_cycle;

endpackage

/* run_sim.sh */
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module core_control_tb -f core_control.f -o core_control_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/core_control_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

exit 0
